/* list.f */
+incdir+test
logic/wb_pkg.sv
logic/wb_master.sv
logic/wb_addr_decoder.sv
logic/wb_ram_slave.sv
logic/wb_fifo_slave.sv
logic/wb_subsystem.sv
test/tb_wb_subsystem.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_wb_subsystem -Mdir obj_dir -f list.f \
    && ./obj_dir/Vtb_wb_subsystem > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0

/* test/wb_ref_model.svh */
`ifndef WB_REF_MODEL_SVH
`define WB_REF_MODEL_SVH

// Which completion pulse a request should end with
typedef enum logic [1:0] {
    WR_DONE,
    WR_ERR,
    RD_DONE,
    RD_ERR
} kind_t;

data_t model_ram [RAM_WORDS];
data_t model_fifo [$];
data_t model_last_read;

function automatic void model_reset();
    for (int i = 0; i < RAM_WORDS; i++) begin
        model_ram[i] = '0;
    end
    model_fifo.delete();
    model_last_read = '0;
endfunction

// 0 is the RAM, 1 the FIFO, 2 nothing mapped
function automatic int model_target(input addr_t addr);
    if (addr[31:16] != 16'h0) begin
        return 2;
    end
    if (addr[15:12] == RAM_REGION) begin
        return 0;
    end
    if (addr[15:12] == FIFO_REGION) begin
        return 1;
    end
    return 2;
endfunction

// RAM word index is adr[7:2] for 64 words
function automatic kind_t model_write(input addr_t addr, input data_t data, input sel_t sel);
    int target;
    target = model_target(addr);
    if (target == 0) begin
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                model_ram[addr[7:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
        return WR_DONE;
    end
    if (target == 1 && model_fifo.size() < FIFO_DEPTH) begin
        model_fifo.push_back(data);
        return WR_DONE;
    end
    // Full FIFO retries until the limit, then fails like an unmapped cycle
    return WR_ERR;
endfunction

function automatic kind_t model_read(input addr_t addr);
    int target;
    target = model_target(addr);
    if (target == 0) begin
        model_last_read = model_ram[addr[7:2]];
        return RD_DONE;
    end
    if (target == 1 && model_fifo.size() > 0) begin
        model_last_read = model_fifo.pop_front();
        return RD_DONE;
    end
    return RD_ERR;
endfunction

`endif

/* test/tb_wb_subsystem.sv */
module tb_wb_subsystem;

    import wb_pkg::*;

    localparam int SEED         = 53558;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_DIRECTED = 19;
    localparam int NUM_RANDOM   = 400;
    localparam int TXN_CYCLES   = int'(MAX_RETRY) * 4 + 10;
    localparam int WATCHDOG_CYCLES =
        (NUM_DIRECTED + NUM_RANDOM) * TXN_CYCLES + RESET_CYCLES + 10;

    logic  clk;
    logic  rst_n;
    logic  write_req_i;
    addr_t write_addr_i;
    data_t write_data_i;
    sel_t  write_sel_i;
    logic  write_done_o;
    logic  write_err_o;
    logic  read_req_i;
    addr_t read_addr_i;
    sel_t  read_sel_i;
    data_t read_data_o;
    logic  read_done_o;
    logic  read_err_o;

    // Cycles from the sampled request to its completion pulse
    int    last_latency;

    `include "wb_ref_model.svh"

    wb_subsystem i_wb_subsystem (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_req_i  (write_req_i),
        .write_addr_i (write_addr_i),
        .write_data_i (write_data_i),
        .write_sel_i  (write_sel_i),
        .write_done_o (write_done_o),
        .write_err_o  (write_err_o),
        .read_req_i   (read_req_i),
        .read_addr_i  (read_addr_i),
        .read_sel_i   (read_sel_i),
        .read_data_o  (read_data_o),
        .read_done_o  (read_done_o),
        .read_err_o   (read_err_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout at %0t: requests did not all complete before the watchdog", $time);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    function automatic int pulse_count();
        return int'(write_done_o) + int'(write_err_o) + int'(read_done_o) + int'(read_err_o);
    endfunction

    function automatic kind_t observed_kind();
        if (write_done_o) begin
            return WR_DONE;
        end
        if (write_err_o) begin
            return WR_ERR;
        end
        if (read_done_o) begin
            return RD_DONE;
        end
        return RD_ERR;
    endfunction

    // Outputs are sampled on the falling edge
    task automatic wait_completion(input kind_t exp_kind);
        kind_t got_kind;
        bit    seen;
        int    cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            assert (pulse_count() <= 1) else report_error("several completion pulses at once");
            if (pulse_count() == 1) begin
                seen     = 1'b1;
                got_kind = observed_kind();
            end
        end
        last_latency = cycles;
        assert (got_kind == exp_kind) else report_error($sformatf(
            "completion %s, expected %s", got_kind.name(), exp_kind.name()));
        assert (read_data_o == model_last_read) else report_error($sformatf(
            "read_data_o %h, expected %h", read_data_o, model_last_read));
        @(negedge clk);
        assert (pulse_count() == 0) else report_error("completion pulse lasted two cycles");
    endtask

    task automatic do_write(input addr_t addr, input data_t data, input sel_t sel);
        kind_t exp_kind;
        exp_kind = model_write(addr, data, sel);
        @(posedge clk);
        write_req_i  <= 1'b1;
        write_addr_i <= addr;
        write_data_i <= data;
        write_sel_i  <= sel;
        @(posedge clk);
        write_req_i <= 1'b0;
        wait_completion(exp_kind);
    endtask

    task automatic do_read(input addr_t addr, input sel_t sel);
        kind_t exp_kind;
        exp_kind = model_read(addr);
        @(posedge clk);
        read_req_i  <= 1'b1;
        read_addr_i <= addr;
        read_sel_i  <= sel;
        @(posedge clk);
        read_req_i <= 1'b0;
        wait_completion(exp_kind);
    endtask

    // Half RAM, three in ten FIFO, the rest unmapped
    function automatic addr_t random_addr();
        int unsigned pick;
        pick = $urandom_range(0, 9);
        if (pick < 5) begin
            return {16'h0, RAM_REGION, 4'h0, 6'($urandom), 2'($urandom)};
        end
        if (pick < 8) begin
            return {16'h0, FIFO_REGION, 12'($urandom)};
        end
        if ($urandom_range(0, 1) == 0) begin
            return {16'h0, 4'($urandom_range(2, 15)), 12'($urandom)};
        end
        return {16'($urandom_range(1, 65535)), 16'($urandom)};
    endfunction

    initial begin
        addr_t       addr;
        data_t       data;
        sel_t        sel;
        addr_t       fifo_addr;

        void'($urandom(SEED));
        fifo_addr    = {16'h0, FIFO_REGION, 12'h0};
        rst_n        = 1'b0;
        write_req_i  = 1'b0;
        write_addr_i = '0;
        write_data_i = '0;
        write_sel_i  = '0;
        read_req_i   = 1'b0;
        read_addr_i  = '0;
        read_sel_i   = '0;
        last_latency = 0;
        model_reset();

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Quiet outputs before any request
        repeat (4) begin
            @(negedge clk);
            assert (pulse_count() == 0) else report_error("completion pulse before any request");
        end

        // Unwritten word, then byte-merged writes
        addr = {16'h0, RAM_REGION, 4'h0, 6'd9, 2'b00};
        do_read(addr, 4'hf);
        for (int i = 0; i < 3; i++) begin
            do_write(addr, $urandom, sel_t'($urandom));
            do_read(addr, 4'hf);
        end

        do_write(32'h0001_0040, 32'hdead_beef, 4'hf);
        do_read({16'h0, 4'h7, 12'h010}, 4'hf);

        // Fill the FIFO, overflow, drain it, underflow
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            do_write(fifo_addr, $urandom, 4'hf);
        end
        // Every refused attempt costs a strobe cycle and a response cycle
        assert (last_latency > 2 * int'(MAX_RETRY)) else report_error(
            "FIFO overflow write failed before the retry limit was used up");
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            do_read(fifo_addr, 4'hf);
        end
        assert (last_latency > 2 * int'(MAX_RETRY)) else report_error(
            "FIFO underflow read failed before the retry limit was used up");

        for (int i = 0; i < NUM_RANDOM; i++) begin
            addr = random_addr();
            data = $urandom;
            sel  = sel_t'($urandom);
            if ($urandom_range(0, 1) == 0) begin
                do_write(addr, data, sel);
            end else begin
                do_read(addr, sel);
            end
        end

        $display("Test passed");
        $finish;
    end

endmodule

/* logic/wb_subsystem.sv */
module wb_subsystem (
    input  logic          clk,
    input  logic          rst_n,

    input  logic          write_req_i,
    input  wb_pkg::addr_t write_addr_i,
    input  wb_pkg::data_t write_data_i,
    input  wb_pkg::sel_t  write_sel_i,
    output logic          write_done_o,
    output logic          write_err_o,

    input  logic          read_req_i,
    input  wb_pkg::addr_t read_addr_i,
    input  wb_pkg::sel_t  read_sel_i,
    output wb_pkg::data_t read_data_o,
    output logic          read_done_o,
    output logic          read_err_o
);

    import wb_pkg::*;

    wb_req_t mst_req;
    wb_rsp_t mst_rsp;
    wb_req_t ram_req;
    wb_rsp_t ram_rsp;
    wb_req_t fifo_req;
    wb_rsp_t fifo_rsp;

    wb_master i_wb_master (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_req_i  (write_req_i),
        .write_addr_i (write_addr_i),
        .write_data_i (write_data_i),
        .write_sel_i  (write_sel_i),
        .write_done_o (write_done_o),
        .write_err_o  (write_err_o),
        .read_req_i   (read_req_i),
        .read_addr_i  (read_addr_i),
        .read_sel_i   (read_sel_i),
        .read_data_o  (read_data_o),
        .read_done_o  (read_done_o),
        .read_err_o   (read_err_o),
        .bus_req_o    (mst_req),
        .bus_rsp_i    (mst_rsp)
    );

    wb_addr_decoder i_wb_addr_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .mst_req_i  (mst_req),
        .mst_rsp_o  (mst_rsp),
        .ram_req_o  (ram_req),
        .ram_rsp_i  (ram_rsp),
        .fifo_req_o (fifo_req),
        .fifo_rsp_i (fifo_rsp)
    );

    wb_ram_slave i_wb_ram_slave (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req_i (ram_req),
        .bus_rsp_o (ram_rsp)
    );

    wb_fifo_slave i_wb_fifo_slave (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req_i (fifo_req),
        .bus_rsp_o (fifo_rsp)
    );

endmodule

/* logic/wb_fifo_slave.sv */
module wb_fifo_slave (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::wb_req_t bus_req_i,
    output wb_pkg::wb_rsp_t bus_rsp_o
);

    import wb_pkg::*;

    data_t                 fifo_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  answered;
    logic                  hit;
    logic                  full;
    logic                  empty;
    logic                  push;
    logic                  pop;

    assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign hit   = bus_req_i.cyc && bus_req_i.stb && !answered;
    assign push  = hit && bus_req_i.we && !full;
    assign pop   = hit && !bus_req_i.we && !empty;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= bus_req_i.dat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            answered  <= 1'b0;
            bus_rsp_o <= '0;
        end else begin
            bus_rsp_o.ack <= 1'b0;
            bus_rsp_o.rty <= 1'b0;
            if (!bus_req_i.stb) begin
                answered <= 1'b0;
            end else if (hit) begin
                answered <= 1'b1;
                // Full on write or empty on read asks for a retry
                if (push) begin
                    wr_ptr        <= wr_ptr + 1'b1;
                    count         <= count + 1'b1;
                    bus_rsp_o.ack <= 1'b1;
                end else if (pop) begin
                    bus_rsp_o.dat <= fifo_mem[rd_ptr];
                    rd_ptr        <= rd_ptr + 1'b1;
                    count         <= count - 1'b1;
                    bus_rsp_o.ack <= 1'b1;
                end else begin
                    bus_rsp_o.rty <= 1'b1;
                end
            end
        end
    end

    // Equal pointers with a nonzero count mean the buffer is full
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> (wr_ptr != rd_ptr) || (count == '0)
    );

endmodule

/* logic/wb_ram_slave.sv */
module wb_ram_slave (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::wb_req_t bus_req_i,
    output wb_pkg::wb_rsp_t bus_rsp_o
);

    import wb_pkg::*;

    data_t                 mem [RAM_WORDS];
    logic [RAM_WAIT_W-1:0] wait_cnt;
    logic [RAM_ADDR_W-1:0] word_idx;
    logic                  answered;
    logic                  hit;

    // Word index sits above the byte offset
    assign word_idx = bus_req_i.adr[RAM_ADDR_W+1:2];
    assign hit      = bus_req_i.cyc && bus_req_i.stb && !answered;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt  <= '0;
            answered  <= 1'b0;
            bus_rsp_o <= '0;
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            bus_rsp_o.ack <= 1'b0;
            if (!bus_req_i.stb) begin
                answered <= 1'b0;
                wait_cnt <= '0;
            end else if (hit) begin
                if (wait_cnt == RAM_WAIT_W'(RAM_WAIT - 1)) begin
                    bus_rsp_o.ack <= 1'b1;
                    answered      <= 1'b1;
                    wait_cnt      <= '0;
                    if (bus_req_i.we) begin
                        // Byte lanes merge into the stored word
                        for (int b = 0; b < $bits(sel_t); b++) begin
                            if (bus_req_i.sel[b]) begin
                                mem[word_idx][8*b +: 8] <= bus_req_i.dat[8*b +: 8];
                            end
                        end
                    end else begin
                        bus_rsp_o.dat <= mem[word_idx];
                    end
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* logic/wb_addr_decoder.sv */
module wb_addr_decoder (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::wb_req_t mst_req_i,
    output wb_pkg::wb_rsp_t mst_rsp_o,
    output wb_pkg::wb_req_t ram_req_o,
    input  wb_pkg::wb_rsp_t ram_rsp_i,
    output wb_pkg::wb_req_t fifo_req_o,
    input  wb_pkg::wb_rsp_t fifo_rsp_i
);

    import wb_pkg::*;

    logic [3:0] region;
    logic       upper_zero;
    logic       ram_sel;
    logic       fifo_sel;
    logic       unmapped;
    logic       err_q;
    logic       err_answered;

    assign region     = mst_req_i.adr[15:12];
    assign upper_zero = (mst_req_i.adr[31:16] == '0);
    assign ram_sel    = upper_zero && (region == RAM_REGION);
    assign fifo_sel   = upper_zero && (region == FIFO_REGION);
    assign unmapped   = !ram_sel && !fifo_sel;

    // Only the selected slave sees the strobe
    always_comb begin
        ram_req_o      = mst_req_i;
        ram_req_o.stb  = mst_req_i.stb && ram_sel;
        fifo_req_o     = mst_req_i;
        fifo_req_o.stb = mst_req_i.stb && fifo_sel;
    end

    always_comb begin
        if (ram_sel) begin
            mst_rsp_o = ram_rsp_i;
        end else if (fifo_sel) begin
            mst_rsp_o = fifo_rsp_i;
        end else begin
            mst_rsp_o     = '0;
            mst_rsp_o.err = err_q;
        end
    end

    // One error pulse per unmapped strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q        <= 1'b0;
            err_answered <= 1'b0;
        end else begin
            err_q <= 1'b0;
            if (!mst_req_i.stb) begin
                err_answered <= 1'b0;
            end else if (unmapped && mst_req_i.cyc && !err_answered) begin
                err_q        <= 1'b1;
                err_answered <= 1'b1;
            end
        end
    end

    a_one_slave_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ram_req_o.stb && fifo_req_o.stb)
    );

endmodule

/* logic/wb_master.sv */
module wb_master (
    input  logic            clk,
    input  logic            rst_n,

    // User write side
    input  logic            write_req_i,
    input  wb_pkg::addr_t   write_addr_i,
    input  wb_pkg::data_t   write_data_i,
    input  wb_pkg::sel_t    write_sel_i,
    output logic            write_done_o,
    output logic            write_err_o,

    // User read side
    input  logic            read_req_i,
    input  wb_pkg::addr_t   read_addr_i,
    input  wb_pkg::sel_t    read_sel_i,
    output wb_pkg::data_t   read_data_o,
    output logic            read_done_o,
    output logic            read_err_o,

    // Bus
    output wb_pkg::wb_req_t bus_req_o,
    input  wb_pkg::wb_rsp_t bus_rsp_i
);

    import wb_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE_WAIT,
        ST_READ_WAIT,
        ST_RETRY
    } state_t;

    state_t     state;
    retry_cnt_t retry_cnt;
    logic       any_rsp;

    assign any_rsp = bus_rsp_i.ack || bus_rsp_i.err || bus_rsp_i.rty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            retry_cnt    <= '0;
            bus_req_o    <= '0;
            write_done_o <= 1'b0;
            write_err_o  <= 1'b0;
            read_data_o  <= '0;
            read_done_o  <= 1'b0;
            read_err_o   <= 1'b0;
        end else begin
            // Completion outputs are single-cycle pulses
            write_done_o <= 1'b0;
            write_err_o  <= 1'b0;
            read_done_o  <= 1'b0;
            read_err_o   <= 1'b0;

            case (state)
                ST_IDLE: begin
                    retry_cnt <= '0;
                    // Write wins when both strobes arrive together
                    if (write_req_i) begin
                        bus_req_o.adr <= write_addr_i;
                        bus_req_o.dat <= write_data_i;
                        bus_req_o.sel <= write_sel_i;
                        bus_req_o.we  <= 1'b1;
                        bus_req_o.stb <= 1'b1;
                        bus_req_o.cyc <= 1'b1;
                        state         <= ST_WRITE_WAIT;
                    end else if (read_req_i) begin
                        bus_req_o.adr <= read_addr_i;
                        bus_req_o.sel <= read_sel_i;
                        bus_req_o.we  <= 1'b0;
                        bus_req_o.stb <= 1'b1;
                        bus_req_o.cyc <= 1'b1;
                        state         <= ST_READ_WAIT;
                    end
                end

                ST_WRITE_WAIT, ST_READ_WAIT: begin
                    // Cycle closes on any response
                    if (any_rsp) begin
                        bus_req_o.stb <= 1'b0;
                        bus_req_o.cyc <= 1'b0;
                    end
                    if (bus_rsp_i.ack) begin
                        state <= ST_IDLE;
                        if (state == ST_WRITE_WAIT) begin
                            write_done_o <= 1'b1;
                        end else begin
                            read_data_o <= bus_rsp_i.dat;
                            read_done_o <= 1'b1;
                        end
                    end else if (bus_rsp_i.err) begin
                        state <= ST_IDLE;
                        if (state == ST_WRITE_WAIT) begin
                            write_err_o <= 1'b1;
                        end else begin
                            read_err_o <= 1'b1;
                        end
                    end else if (bus_rsp_i.rty) begin
                        retry_cnt <= retry_cnt + 1'b1;
                        state     <= ST_RETRY;
                    end
                end

                ST_RETRY: begin
                    if (retry_cnt >= MAX_RETRY) begin
                        // Give up, report as error
                        state <= ST_IDLE;
                        if (bus_req_o.we) begin
                            write_err_o <= 1'b1;
                        end else begin
                            read_err_o <= 1'b1;
                        end
                    end else begin
                        bus_req_o.stb <= 1'b1;
                        bus_req_o.cyc <= 1'b1;
                        state <= bus_req_o.we ? ST_WRITE_WAIT : ST_READ_WAIT;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    a_stb_within_cyc: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus_req_o.stb |-> bus_req_o.cyc
    );

    a_single_completion: assert property (
        @(posedge clk) disable iff (!rst_n)
        !((write_done_o || read_done_o) && (write_err_o || read_err_o))
    );

endmodule

/* logic/wb_pkg.sv */
package wb_pkg;

    // Bus widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  sel_t;
    typedef logic [3:0]  retry_cnt_t;

    // Master to slave
    typedef struct packed {
        addr_t adr;
        data_t dat;
        logic  we;
        sel_t  sel;
        logic  stb;
        logic  cyc;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        data_t dat;
        logic  ack;
        logic  err;
        logic  rty;
    } wb_rsp_t;

    // Attempts answered with retry before the request fails
    localparam retry_cnt_t MAX_RETRY = 4'd8;

    // RAM slave
    localparam int RAM_WORDS  = 64;
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);
    localparam int RAM_WAIT   = 2;
    localparam int RAM_WAIT_W = $clog2(RAM_WAIT + 1);

    // FIFO slave
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // Region is adr[15:12] when adr[31:16] is zero
    localparam logic [3:0] RAM_REGION  = 4'd0;
    localparam logic [3:0] FIFO_REGION = 4'd1;

endpackage
